// File: hdl/wbdbg_pkg.sv
package wbdbg_pkg;

    // word layout shared by the command and the response streams
    localparam int WORD_BITS    = 34;
    localparam int SUB_BITS     = 2;
    localparam int PAYLOAD_BITS = 32;
    localparam int BYTE_BITS    = 8;
    // bytes per word on the serial side, sub-code byte first
    localparam int WORD_BYTES   = 5;
    localparam int FRAME_BITS   = WORD_BYTES * BYTE_BITS;
    localparam int BYTE_CNT_BITS = $clog2(WORD_BYTES);

    // wishbone widths, word addressed
    localparam int WB_ADDR_BITS = 30;
    localparam int WB_DATA_BITS = 32;
    localparam int WB_SEL_BITS  = 4;

    // scratch ram depth, anything at or above answers with err
    localparam int RAM_WORDS     = 256;
    localparam int RAM_ADDR_BITS = $clog2(RAM_WORDS);

    // set-address payload bit that turns on auto-increment
    localparam int ADDR_INC_BIT = 30;

    typedef logic [WORD_BITS-1:0]     cmd_word_t;
    typedef logic [WORD_BITS-1:0]     rsp_word_t;
    typedef logic [SUB_BITS-1:0]      sub_code_t;
    typedef logic [BYTE_BITS-1:0]     byte_t;
    typedef logic [FRAME_BITS-1:0]    frame_t;
    typedef logic [BYTE_CNT_BITS-1:0] byte_cnt_t;
    typedef logic [WB_ADDR_BITS-1:0]  wb_addr_t;
    typedef logic [WB_DATA_BITS-1:0]  wb_data_t;
    typedef logic [WB_SEL_BITS-1:0]   wb_sel_t;
    typedef logic [RAM_ADDR_BITS-1:0] ram_addr_t;

    // command sub-codes, bit 33 clear marks a bus access
    localparam sub_code_t CMD_SUB_RD      = 2'd0;
    localparam sub_code_t CMD_SUB_WR      = 2'd1;
    localparam sub_code_t CMD_SUB_ADDR    = 2'd2;
    localparam sub_code_t CMD_SUB_SPECIAL = 2'd3;

    // response sub-codes
    localparam sub_code_t RSP_SUB_DATA    = 2'd0;
    localparam sub_code_t RSP_SUB_ACK     = 2'd1;
    localparam sub_code_t RSP_SUB_ADDR    = 2'd2;
    localparam sub_code_t RSP_SUB_SPECIAL = 2'd3;

    // fixed response words
    localparam rsp_word_t RSP_RESET_WORD     = {RSP_SUB_SPECIAL, 32'h0000_0000};
    localparam rsp_word_t RSP_BUS_ERROR_WORD = {RSP_SUB_SPECIAL, 3'h1, 29'h0};
    localparam rsp_word_t RSP_WRITE_ACK_WORD = {RSP_SUB_ACK, 32'h0000_0000};

    // bus master sequencing
    typedef enum logic [1:0] {
        MST_IDLE,
        MST_REQUEST,
        MST_WAIT,
        MST_RESPOND
    } master_state_t;

endpackage

// File: hdl/cmd_word_assembler.sv
`timescale 1ns/10ps

module cmd_word_assembler
    import wbdbg_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    // byte stream from the receiver
    input  logic      i_rx_stb,
    input  byte_t     i_rx_byte,
    // downstream busy levels
    input  logic      i_bus_busy,
    input  logic      i_rsp_busy,
    // assembled command
    output logic      o_cmd_stb,
    output cmd_word_t o_cmd_word
);

    localparam byte_cnt_t LAST_BYTE = byte_cnt_t'(WORD_BYTES - 1);

    byte_cnt_t byte_cnt_q;
    logic      full_q;
    logic      byte_take;
    logic      cmd_xfer;

    // bytes only shift in while no finished word is waiting
    assign byte_take = i_rx_stb && !full_q;

    // a finished word is offered only when the response path is free,
    // so the answer to it always finds the serializer empty
    assign o_cmd_stb = full_q && !i_rsp_busy;
    assign cmd_xfer  = o_cmd_stb && !i_bus_busy;

    // byte counter and word-held flag
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            byte_cnt_q <= '0;
            full_q     <= 1'b0;
        end else begin
            if (cmd_xfer) begin
                full_q <= 1'b0;
            end else if (byte_take) begin
                if (byte_cnt_q == LAST_BYTE) begin
                    // fifth byte in, stb goes high next cycle
                    byte_cnt_q <= '0;
                    full_q     <= 1'b1;
                end else begin
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                end
            end
        end
    end

    // msb-first shift, the sub-code byte ends up in bits 33..32
    // and its six upper bits fall off the top
    always_ff @(posedge i_clk) begin
        if (byte_take) begin
            o_cmd_word <= {o_cmd_word[WORD_BITS-BYTE_BITS-1:0], i_rx_byte};
        end
    end

    // sender must wait for the response before the next command
    a_no_byte_while_full: assert property (
        @(posedge i_clk) disable iff (i_reset)
        full_q |-> !i_rx_stb
    );

endmodule

// File: hdl/wb_bus_master.sv
`timescale 1ns/10ps

module wb_bus_master
    import wbdbg_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    // command channel
    input  logic      i_cmd_stb,
    input  cmd_word_t i_cmd_word,
    output logic      o_bus_busy,
    // response channel
    output logic      o_rsp_stb,
    output rsp_word_t o_rsp_word,
    // wishbone master side
    output logic      o_wb_cyc,
    output logic      o_wb_stb,
    output logic      o_wb_we,
    output wb_addr_t  o_wb_addr,
    output wb_data_t  o_wb_data,
    output wb_sel_t   o_wb_sel,
    input  logic      i_wb_stall,
    input  logic      i_wb_ack,
    input  logic      i_wb_err,
    input  wb_data_t  i_wb_rdata
);

    master_state_t state_q;
    logic          addr_inc_q;
    logic          echo_pend_q;
    sub_code_t     cmd_sub;
    logic          cmd_take;
    logic          cmd_bus;
    logic          bus_done;

    // decode the word in its own strobe cycle
    assign cmd_sub  = i_cmd_word[WORD_BITS-1 -: SUB_BITS];
    assign cmd_take = i_cmd_stb && !o_bus_busy;
    assign cmd_bus  = (cmd_sub == CMD_SUB_RD) || (cmd_sub == CMD_SUB_WR);
    assign bus_done = (state_q == MST_WAIT) && (i_wb_ack || i_wb_err);

    assign o_bus_busy = o_wb_cyc || echo_pend_q;
    // full-word accesses only
    assign o_wb_sel   = '1;

    // sequencer, address register and auto-increment flag
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q     <= MST_IDLE;
            o_wb_cyc    <= 1'b0;
            o_wb_stb    <= 1'b0;
            echo_pend_q <= 1'b0;
            o_wb_addr   <= '0;
            addr_inc_q  <= 1'b0;
        end else begin
            case (state_q)
                // respond behaves as idle, the pulse is already out
                MST_IDLE, MST_RESPOND: begin
                    state_q     <= MST_IDLE;
                    echo_pend_q <= 1'b0;
                    if (cmd_take && cmd_bus) begin
                        state_q  <= MST_REQUEST;
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                    end else if (cmd_take && (cmd_sub == CMD_SUB_ADDR)) begin
                        o_wb_addr   <= i_cmd_word[WB_ADDR_BITS-1:0];
                        addr_inc_q  <= i_cmd_word[ADDR_INC_BIT];
                        echo_pend_q <= 1'b1;
                    end
                    // CMD_SUB_SPECIAL is reserved and dropped here
                end
                MST_REQUEST: begin
                    // one access per command, stb drops once taken
                    if (!i_wb_stall) begin
                        o_wb_stb <= 1'b0;
                        state_q  <= MST_WAIT;
                    end
                end
                MST_WAIT: begin
                    if (bus_done) begin
                        o_wb_cyc <= 1'b0;
                        state_q  <= MST_RESPOND;
                    end
                    // an err leaves the address where it was
                    if (i_wb_ack && !i_wb_err && addr_inc_q) begin
                        o_wb_addr <= o_wb_addr + 1'b1;
                    end
                end
                default: state_q <= MST_IDLE;
            endcase
        end
    end

    // direction and write data captured with the command
    always_ff @(posedge i_clk) begin
        if (cmd_take && cmd_bus) begin
            o_wb_we   <= (cmd_sub == CMD_SUB_WR);
            o_wb_data <= i_cmd_word[PAYLOAD_BITS-1:0];
        end
    end

    // response pulse, stb is held through reset so the
    // reset word leaves on the first cycle after it
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rsp_stb  <= 1'b1;
            o_rsp_word <= RSP_RESET_WORD;
        end else begin
            o_rsp_stb <= bus_done || echo_pend_q;
            if (bus_done && i_wb_err) begin
                o_rsp_word <= RSP_BUS_ERROR_WORD;
            end else if (bus_done) begin
                o_rsp_word <= o_wb_we ? RSP_WRITE_ACK_WORD : {RSP_SUB_DATA, i_wb_rdata};
            end else if (echo_pend_q) begin
                // echo carries the flag in bit 30
                o_rsp_word <= {RSP_SUB_ADDR, 1'b0, addr_inc_q, o_wb_addr};
            end
        end
    end

    a_stb_in_cyc: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_wb_stb |-> o_wb_cyc
    );

    // slave answers one way only
    a_ack_xor_err: assert property (
        @(posedge i_clk) disable iff (i_reset)
        !(i_wb_ack && i_wb_err)
    );

    // no new command while the previous answer is still being handed over
    a_take_when_free: assert property (
        @(posedge i_clk) disable iff (i_reset)
        cmd_take |-> !o_rsp_stb
    );

endmodule

// File: hdl/rsp_word_serializer.sv
`timescale 1ns/10ps

module rsp_word_serializer
    import wbdbg_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    // response word from the bus master
    input  logic      i_rsp_stb,
    input  rsp_word_t i_rsp_word,
    // transmitter handshake
    input  logic      i_tx_busy,
    output logic      o_rsp_busy,
    output logic      o_tx_stb,
    output byte_t     o_tx_byte
);

    localparam byte_cnt_t LAST_BYTE = byte_cnt_t'(WORD_BYTES - 1);

    frame_t    shift_q;
    byte_cnt_t byte_cnt_q;
    logic      gap_q;

    // a byte goes out whenever the transmitter is free,
    // never back to back
    assign o_tx_stb  = o_rsp_busy && !gap_q && !i_tx_busy;
    assign o_tx_byte = shift_q[FRAME_BITS-1 -: BYTE_BITS];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rsp_busy <= 1'b0;
            byte_cnt_q <= '0;
            gap_q      <= 1'b0;
        end else if (i_rsp_stb) begin
            o_rsp_busy <= 1'b1;
            byte_cnt_q <= '0;
            gap_q      <= 1'b0;
        end else if (o_tx_stb) begin
            gap_q <= 1'b1;
            if (byte_cnt_q == LAST_BYTE) begin
                // busy drops the cycle after the fifth byte
                o_rsp_busy <= 1'b0;
                byte_cnt_q <= '0;
            end else begin
                byte_cnt_q <= byte_cnt_q + 1'b1;
            end
        end else begin
            gap_q <= 1'b0;
        end
    end

    // zero-padded so the first byte is just the sub-code,
    // payload then leaves msb first
    always_ff @(posedge i_clk) begin
        if (i_rsp_stb) begin
            shift_q <= frame_t'(i_rsp_word);
        end else if (o_tx_stb) begin
            shift_q <= shift_q << BYTE_BITS;
        end
    end

    // relies on the assembler holding commands while busy
    a_no_rsp_while_busy: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_rsp_stb |-> !o_rsp_busy
    );

endmodule

// File: hdl/wb_scratch_ram.sv
`timescale 1ns/10ps

module wb_scratch_ram
    import wbdbg_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset,
    // wishbone slave side
    input  logic     i_wb_cyc,
    input  logic     i_wb_stb,
    input  logic     i_wb_we,
    input  wb_addr_t i_wb_addr,
    input  wb_data_t i_wb_data,
    input  wb_sel_t  i_wb_sel,
    output logic     o_wb_stall,
    output logic     o_wb_ack,
    output logic     o_wb_err,
    output wb_data_t o_wb_rdata
);

    wb_data_t  mem [RAM_WORDS];
    logic      armed_q;
    logic      req;
    logic      accept;
    logic      in_range;
    ram_addr_t ram_idx;

    assign req      = i_wb_cyc && i_wb_stb;
    // first cycle of each request is always stalled
    assign o_wb_stall = req && !armed_q;
    assign accept   = req && armed_q;
    assign in_range = (i_wb_addr < wb_addr_t'(RAM_WORDS));
    assign ram_idx  = i_wb_addr[RAM_ADDR_BITS-1:0];

    // armed after the stall cycle, cleared by the acceptance
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            armed_q  <= 1'b0;
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
        end else begin
            armed_q  <= req && !armed_q;
            // answer lands exactly one cycle after acceptance
            o_wb_ack <= accept && in_range;
            o_wb_err <= accept && !in_range;
        end
    end

    // out-of-range requests never touch the array
    always_ff @(posedge i_clk) begin
        if (accept && in_range) begin
            o_wb_rdata <= mem[ram_idx];
            if (i_wb_we) begin
                for (int lane = 0; lane < WB_SEL_BITS; lane++) begin
                    if (i_wb_sel[lane]) begin
                        mem[ram_idx][lane*BYTE_BITS +: BYTE_BITS] <=
                            i_wb_data[lane*BYTE_BITS +: BYTE_BITS];
                    end
                end
            end
        end
    end

    // master issues a single access per cycle, no follow-on request
    a_single_access: assert property (
        @(posedge i_clk) disable iff (i_reset)
        accept |=> !i_wb_stb
    );

endmodule

// File: hdl/wbdbg_top.sv
`timescale 1ns/10ps

module wbdbg_top
    import wbdbg_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_reset,
    input  logic  i_rx_stb,
    input  byte_t i_rx_byte,
    input  logic  i_tx_busy,
    output logic  o_tx_stb,
    output byte_t o_tx_byte
);

    // command path
    logic      cmd_stb;
    cmd_word_t cmd_word;
    logic      bus_busy;
    // response path
    logic      rsp_stb;
    rsp_word_t rsp_word;
    logic      rsp_busy;
    // wishbone between master and scratch ram
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    wb_addr_t  wb_addr;
    wb_data_t  wb_data;
    wb_sel_t   wb_sel;
    logic      wb_stall;
    logic      wb_ack;
    logic      wb_err;
    wb_data_t  wb_rdata;

    cmd_word_assembler u_asm (
        .i_clk, .i_reset, .i_rx_stb, .i_rx_byte,
        .i_bus_busy(bus_busy), .i_rsp_busy(rsp_busy),
        .o_cmd_stb(cmd_stb), .o_cmd_word(cmd_word)
    );

    wb_bus_master u_master (
        .i_clk, .i_reset,
        .i_cmd_stb(cmd_stb), .i_cmd_word(cmd_word), .o_bus_busy(bus_busy),
        .o_rsp_stb(rsp_stb), .o_rsp_word(rsp_word),
        .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_we(wb_we),
        .o_wb_addr(wb_addr), .o_wb_data(wb_data), .o_wb_sel(wb_sel),
        .i_wb_stall(wb_stall), .i_wb_ack(wb_ack), .i_wb_err(wb_err),
        .i_wb_rdata(wb_rdata)
    );

    rsp_word_serializer u_ser (
        .i_clk, .i_reset,
        .i_rsp_stb(rsp_stb), .i_rsp_word(rsp_word),
        .i_tx_busy, .o_rsp_busy(rsp_busy), .o_tx_stb, .o_tx_byte
    );

    wb_scratch_ram u_ram (
        .i_clk, .i_reset,
        .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
        .i_wb_addr(wb_addr), .i_wb_data(wb_data), .i_wb_sel(wb_sel),
        .o_wb_stall(wb_stall), .o_wb_ack(wb_ack), .o_wb_err(wb_err),
        .o_wb_rdata(wb_rdata)
    );

endmodule

// File: dv/wbdbg_tb.sv
`timescale 1ns/10ps

module wbdbg_tb
    import wbdbg_pkg::*;
;

    localparam int CLK_PERIOD     = 10;
    // reset word, echo pair, preload, write/read, burst, error phase, random mix
    localparam int TOTAL_CMDS     = 1 + 2 + 257 + 4 + 18 + 8 + 60;
    localparam int CYCLES_PER_CMD = 100;
    localparam int TIMEOUT_NS     = TOTAL_CMDS * CYCLES_PER_CMD * CLK_PERIOD;

    logic  i_clk = 1'b0;
    logic  i_reset;
    logic  i_rx_stb;
    byte_t i_rx_byte;
    logic  i_tx_busy = 1'b0;
    logic  o_tx_stb;
    byte_t o_tx_byte;

    logic        busy_on = 1'b0;
    logic [31:0] lfsr_q = 32'hba9b_c80c;
    int          err_cnt = 0;
    int          done_cnt = 0;
    int          expected_cnt = 0;
    rsp_word_t   got_q[$];
    rsp_word_t   exp_q[$];
    string       name_q[$];
    // reference state of the master and the scratch ram
    wb_addr_t    ref_addr = '0;
    logic        ref_inc = 1'b0;
    wb_data_t    ref_mem [RAM_WORDS];
    // collector state
    int          rx_idx = 0;
    frame_t      frame_q = '0;

    wbdbg_top u_dut (
        .i_clk, .i_reset, .i_rx_stb, .i_rx_byte, .i_tx_busy, .o_tx_stb, .o_tx_byte
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // galois form, one step per bit handed out
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    function automatic cmd_word_t addr_cmd(input wb_addr_t a, input logic inc);
        return {CMD_SUB_ADDR, 1'b0, inc, a};
    endfunction

    // every byte lane depends on the full ram index
    function automatic wb_data_t fill_word(input ram_addr_t a);
        return {a ^ 8'ha5, ~a, a, a ^ 8'h3c};
    endfunction

    // expected answer per command, returns 0 when none is due
    function automatic logic model_cmd(input cmd_word_t cmd, output rsp_word_t rsp);
        sub_code_t sub;
        sub = cmd[WORD_BITS-1 -: SUB_BITS];
        rsp = '0;
        if (sub == CMD_SUB_SPECIAL) begin
            return 1'b0;
        end
        if (sub == CMD_SUB_ADDR) begin
            ref_addr = cmd[WB_ADDR_BITS-1:0];
            ref_inc  = cmd[ADDR_INC_BIT];
            rsp      = {RSP_SUB_ADDR, 1'b0, ref_inc, ref_addr};
            return 1'b1;
        end
        // out of range, error word and the address stays put
        if (ref_addr >= wb_addr_t'(RAM_WORDS)) begin
            rsp = RSP_BUS_ERROR_WORD;
            return 1'b1;
        end
        if (sub == CMD_SUB_WR) begin
            ref_mem[ram_addr_t'(ref_addr)] = cmd[PAYLOAD_BITS-1:0];
            rsp = RSP_WRITE_ACK_WORD;
        end else begin
            rsp = {RSP_SUB_DATA, ref_mem[ram_addr_t'(ref_addr)]};
        end
        if (ref_inc) begin
            ref_addr = ref_addr + 30'd1;
        end
        return 1'b1;
    endfunction

    task automatic check_word(input string name, input rsp_word_t exp, input rsp_word_t act);
        if (exp !== act) begin
            err_cnt++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    // sub-code byte first, payload msb first
    task automatic send_bytes(input cmd_word_t cmd);
        frame_t f;
        f = frame_t'(cmd);
        for (int b = 0; b < WORD_BYTES; b++) begin
            @(negedge i_clk);
            i_rx_stb  = 1'b1;
            i_rx_byte = f[FRAME_BITS-1 -: BYTE_BITS];
            f = f << BYTE_BITS;
        end
        @(negedge i_clk);
        i_rx_stb = 1'b0;
    endtask

    task automatic issue_cmd(input string name, input cmd_word_t cmd);
        rsp_word_t exp;
        if (model_cmd(cmd, exp)) begin
            exp_q.push_back(exp);
            name_q.push_back(name);
            expected_cnt++;
            send_bytes(cmd);
            // response fully out before the next command
            while (done_cnt < expected_cnt) begin
                @(negedge i_clk);
            end
        end else begin
            // special words are dropped, just let the assembler clear
            send_bytes(cmd);
            repeat (3) @(negedge i_clk);
        end
    endtask

    always @(negedge i_clk) begin
        if (busy_on) begin
            i_tx_busy <= (lfsr_bits(1) != 0);
        end
    end

    // byte collector, five strobes make one response word
    always @(posedge i_clk) begin
        if (!i_reset && o_tx_stb) begin
            if (rx_idx == 0 && o_tx_byte[BYTE_BITS-1:SUB_BITS] != '0) begin
                err_cnt++;
                $display("first byte of a response has upper bits set: %h", o_tx_byte);
            end
            frame_q = {frame_q[FRAME_BITS-BYTE_BITS-1:0], o_tx_byte};
            if (rx_idx == WORD_BYTES - 1) begin
                got_q.push_back(rsp_word_t'(frame_q));
                rx_idx = 0;
            end else begin
                rx_idx++;
            end
        end
    end

    always @(negedge i_clk) begin
        rsp_word_t got;
        while (got_q.size() > 0) begin
            got = got_q.pop_front();
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("response %h arrived with no command outstanding", got);
            end else begin
                check_word(name_q.pop_front(), exp_q.pop_front(), got);
            end
            done_cnt++;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout, %0d of %0d responses arrived", done_cnt, expected_cnt);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        sub_code_t   sub;
        i_reset   = 1'b1;
        i_rx_stb  = 1'b0;
        i_rx_byte = '0;
        // the reset word is the first response after release
        exp_q.push_back(RSP_RESET_WORD);
        name_q.push_back("reset_word");
        expected_cnt = 1;
        repeat (4) @(negedge i_clk);
        i_reset = 1'b0;
        while (done_cnt < expected_cnt) begin
            @(negedge i_clk);
        end
        issue_cmd("addr_echo_inc", {CMD_SUB_ADDR, 32'h4000_0123});
        issue_cmd("addr_echo_noinc", {CMD_SUB_ADDR, 32'h0abc_def0});
        // preload the whole ram through an auto-incrementing write run
        issue_cmd("preload_addr", addr_cmd('0, 1'b1));
        for (int i = 0; i < RAM_WORDS; i++) begin
            issue_cmd("preload_wr", {CMD_SUB_WR, fill_word(ram_addr_t'(i))});
        end
        a = lfsr_bits(RAM_ADDR_BITS);
        issue_cmd("wr_addr", addr_cmd(wb_addr_t'(a), 1'b0));
        issue_cmd("wr_single", {CMD_SUB_WR, lfsr_bits(32)});
        issue_cmd("rd_addr", addr_cmd(wb_addr_t'(a), 1'b0));
        issue_cmd("rd_single", {CMD_SUB_RD, 32'h0});
        a = lfsr_bits(7);
        issue_cmd("burst_wr_addr", addr_cmd(wb_addr_t'(a), 1'b1));
        for (int i = 0; i < 8; i++) begin
            issue_cmd("burst_wr", {CMD_SUB_WR, lfsr_bits(32)});
        end
        issue_cmd("burst_rd_addr", addr_cmd(wb_addr_t'(a), 1'b1));
        for (int i = 0; i < 8; i++) begin
            issue_cmd("burst_rd", {CMD_SUB_RD, 32'h0});
        end
        // top of the address space, an advance would wrap back into range
        issue_cmd("err_addr_top", addr_cmd('1, 1'b1));
        issue_cmd("err_rd", {CMD_SUB_RD, 32'h0});
        issue_cmd("err_wr", {CMD_SUB_WR, lfsr_bits(32)});
        issue_cmd("err_rd_again", {CMD_SUB_RD, 32'h0});
        issue_cmd("err_addr_edge", addr_cmd(wb_addr_t'(RAM_WORDS), 1'b1));
        issue_cmd("err_rd_edge", {CMD_SUB_RD, 32'h0});
        issue_cmd("after_err_addr", addr_cmd(30'd5, 1'b0));
        issue_cmd("after_err_rd", {CMD_SUB_RD, 32'h0});
        // random mix with a random transmitter busy level
        busy_on = 1'b1;
        for (int k = 0; k < 60; k++) begin
            sub = sub_code_t'(lfsr_bits(SUB_BITS));
            d   = lfsr_bits(32);
            if (sub == CMD_SUB_ADDR) begin
                // mostly in range, now and then just past the top
                a = lfsr_bits(RAM_ADDR_BITS);
                a[RAM_ADDR_BITS] = (lfsr_bits(3) == 0);
                d = {1'b0, d[ADDR_INC_BIT], wb_addr_t'(a)};
            end
            issue_cmd("random_mix", {sub, d});
        end
        busy_on = 1'b0;
        // anything late shows up as an unmatched response
        repeat (40) @(negedge i_clk);
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("%0d expected responses never arrived", exp_q.size());
        end
        $display("checked %0d responses, %0d errors", done_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
hdl/wbdbg_pkg.sv
hdl/cmd_word_assembler.sv
hdl/wb_bus_master.sv
hdl/rsp_word_serializer.sv
hdl/wb_scratch_ram.sv
hdl/wbdbg_top.sv
dv/wbdbg_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the serial wishbone debug bridge testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module wbdbg_tb -f tb.f -o wbdbg_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/wbdbg_sim)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
